/* flist.f */
common/tk1_reg_pkg.sv
common/tk1_types_pkg.sv
source/udi_rom.sv
source/status_led.sv
security_monitor/security_monitor.sv
source/tk1_api.sv
source/tk1_core.sv
tb/tk1_core_properties.sv
tb/tb_tk1_core.sv

/* tb/tb_tk1_core.sv */
`timescale 1ns/1ps

module tb_tk1_core;
  import tk1_reg_pkg::*;
  import tk1_types_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_RESETS   = 8;
  localparam int TEST_CYCLES  = 3000;

  // Reference model state for every software-visible effect
  typedef struct packed {
    logic                       app_mode, cdi_ok, mon_en, trap, blink_r, g3, g4;
    logic [2:0]                 led;
    logic [1:0]                 g1, g2;
    logic [31:0]                start, size, blake, scramble, first, last;
    logic [ASLR_WIDTH-1:0]      aslr;
    logic [TRAP_BLINK_BITS-1:0] blink_ctr;
    logic [7:0][31:0]           cdi;
  } model_t;

  logic                  clk, reset_n, cs, cpu_trap, gpio1, gpio2;
  bus_req_t              req;
  cpu_access_t           cpu;
  logic [31:0]           read_data, ram_scramble;
  logic [ASLR_WIDTH-1:0] ram_aslr;
  logic                  ready, fw_app_mode, force_trap, led_r, led_g, led_b, gpio3, gpio4;
  model_t                m;
  bit                    model_valid;
  int                    check_count, error_count;

  tk1_core uut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog sized from the scenario lengths plus margin
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + NUM_RESETS * RESET_CYCLES + 200));
    $display("Timeout: the run did not reach its end in the expected time");
    $display("Done: errors found");
    $finish;
  end

  function automatic logic violation(cpu_access_t a);
    logic in_fw;
    logic in_win;
    in_fw  = (a.addr >= FW_RAM_FIRST) && (a.addr <= FW_RAM_LAST);
    in_win = m.mon_en && (a.addr >= m.first) && (a.addr <= m.last);
    return a.valid && (((a.addr[31:30] == 2'b01) && (a.addr[29:17] != 0)) ||
                       (a.instr && (in_fw || in_win)));
  endfunction

  function automatic logic [31:0] expected_read();
    logic [31:0] d;
    d = '0;
    if (cs && !req.we) begin
      case (req.address)
        ADDR_NAME0:      d = CORE_NAME0;
        ADDR_NAME1:      d = CORE_NAME1;
        ADDR_VERSION:    d = CORE_VERSION;
        ADDR_SWITCH_APP: d = {32{m.app_mode}};
        ADDR_LED:        d = {29'h0, m.led};
        ADDR_GPIO:       d = {28'h0, m.g4, m.g3, m.g2[1], m.g1[1]};
        ADDR_APP_START:  d = m.start;
        ADDR_APP_SIZE:   d = m.size;
        ADDR_BLAKE2S:    d = m.blake;
        default: begin
          if (req.address inside {[ADDR_CDI_FIRST:ADDR_CDI_LAST]} && m.cdi_ok)
            d = m.cdi[req.address[2:0]];
          if (req.address inside {[ADDR_UDI_FIRST:ADDR_UDI_LAST]} && !m.app_mode)
            d = req.address[0] ? UDI_WORD1 : UDI_WORD0;
        end
      endcase
    end
    return d;
  endfunction

  // Advance the model by one clock edge using the inputs held over that edge
  task automatic update_model();
    if (!reset_n) begin
      m = '0;
      m.led = LED_RESET;
      m.cdi_ok = 1'b1;
      model_valid = 1'b1;
    end else begin
      if (violation(cpu)) m.trap = 1'b1;
      if (m.blink_ctr == 0) m.blink_r = ~m.blink_r;
      m.blink_ctr = m.blink_ctr + 1'b1;
      m.g1 = {m.g1[0], gpio1};
      m.g2 = {m.g2[0], gpio2};
      if (cs && req.we) begin
        if (req.address inside {[ADDR_CDI_FIRST:ADDR_CDI_LAST]} && !m.app_mode)
          m.cdi[req.address[2:0]] = req.write_data;
        else
          m.cdi_ok = 1'b0;
        case (req.address)
          ADDR_SWITCH_APP:    m.app_mode = 1'b1;
          ADDR_LED:           m.led = req.write_data[2:0];
          ADDR_GPIO:          {m.g4, m.g3} = req.write_data[GPIO4_BIT:GPIO3_BIT];
          ADDR_APP_START:     if (!m.app_mode) m.start = req.write_data;
          ADDR_APP_SIZE:      if (!m.app_mode) m.size = req.write_data;
          ADDR_BLAKE2S:       if (!m.app_mode) m.blake = req.write_data;
          ADDR_RAM_ASLR:      if (!m.app_mode) m.aslr = req.write_data[ASLR_WIDTH-1:0];
          ADDR_RAM_SCRAMBLE:  if (!m.app_mode) m.scramble = req.write_data;
          ADDR_CPU_MON_CTRL:  m.mon_en = 1'b1;
          ADDR_CPU_MON_FIRST: if (!m.mon_en) m.first = req.write_data;
          ADDR_CPU_MON_LAST:  if (!m.mon_en) m.last = req.write_data;
          default: ;
        endcase
      end
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Checks outputs at the falling edge and returns 1 ns after the next rising edge
  task automatic tick();
    @(negedge clk);
    if (model_valid) begin
      check_value("read_data", read_data, expected_read());
      check_value("ready", ready, cs);
      check_value("fw_app_mode", fw_app_mode, m.app_mode);
      check_value("force_trap", force_trap, m.trap);
      check_value("ram_aslr", ram_aslr, m.aslr);
      check_value("ram_scramble", ram_scramble, m.scramble);
      check_value("led", {led_r, led_g, led_b}, cpu_trap ? {m.blink_r, 2'b00} : m.led);
      check_value("gpio3", gpio3, m.g3);
      check_value("gpio4", gpio4, m.g4);
    end
    @(posedge clk);
    update_model();
    #1;
    gpio1 = 1'($urandom);
    gpio2 = 1'($urandom);
  endtask

  task automatic bus_write(logic [7:0] addr, logic [31:0] data);
    cs = 1'b1;
    req = '{we: 1'b1, address: addr, write_data: data};
    tick();
  endtask

  task automatic bus_read(logic [7:0] addr);
    cs = 1'b1;
    req = '{we: 1'b0, address: addr, write_data: $urandom};
    tick();
  endtask

  task automatic bus_idle();
    cs = 1'b0;
    req.address = 8'($urandom);
    tick();
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    cs = 1'b0;
    cpu = '0;
    cpu_trap = 1'b0;
    repeat (RESET_CYCLES) tick();
    reset_n = 1'b1;
  endtask

  function automatic logic [7:0] lockable_addr();
    case ($urandom % 6)
      0:       return ADDR_APP_START;
      1:       return ADDR_APP_SIZE;
      2:       return ADDR_BLAKE2S;
      3:       return ADDR_RAM_ASLR;
      4:       return ADDR_RAM_SCRAMBLE;
      default: return ADDR_CDI_FIRST + 8'($urandom % 8);
    endcase
  endfunction

  // Mostly benign RAM traffic with some firmware RAM, out-of-range and window hits
  function automatic cpu_access_t random_access(logic [31:0] win, bit window_only);
    cpu_access_t a;
    a.valid = ($urandom % 4) != 0;
    a.instr = 1'($urandom);
    if (window_only) begin
      // Only the armed window can trap here
      if ($urandom % 2) a.addr = win + $urandom % 32'h800;
      else a.addr = 32'h4000_0000 + $urandom % 32'h2_0000;
    end else begin
      case ($urandom % 10)
        6:       a.addr = FW_RAM_FIRST + $urandom % 32'h1000;
        7:       a.addr = 32'h4000_0000 | ($urandom % 32'h4000_0000);
        8:       a.addr = win + $urandom % 32'h800;
        9:       a.addr = $urandom;
        default: a.addr = 32'h4000_0000 + $urandom % 32'h2_0000;
      endcase
    end
    return a;
  endfunction

  initial begin
    int          r;
    logic [31:0] base;
    void'($urandom(32'h552db295));
    {cs, req, cpu, cpu_trap, gpio1, gpio2} = '0;
    check_count = 0;
    error_count = 0;
    model_valid = 1'b0;

    // Identity words, reset values and a sweep of the address map
    apply_reset();
    for (int i = 0; i < 200; i++) bus_read(i < 128 ? 8'(i) : 8'($urandom));

    // Lockable registers before and after the switch
    apply_reset();
    for (int i = 0; i < 800; i++) begin
      if (i == 400) bus_write(ADDR_SWITCH_APP, $urandom);
      else if ($urandom % 2) bus_write(lockable_addr(), $urandom);
      else bus_read(lockable_addr());
    end

    // CDI hiding and UDI visibility
    apply_reset();
    for (int i = 0; i < 500; i++) begin
      r = $urandom % 64;
      if (i == 250) bus_write(ADDR_SWITCH_APP, $urandom);
      else if (r < 24) bus_write(ADDR_CDI_FIRST + 8'($urandom % 8), $urandom);
      else if (r < 44) bus_read(ADDR_CDI_FIRST + 8'($urandom % 8));
      else if (r < 63) bus_read(ADDR_UDI_FIRST + 8'(r % 2));
      else bus_write(ADDR_LED, $urandom);
    end

    // Security monitor with one armed window per run
    for (int run = 0; run < 4; run++) begin
      apply_reset();
      base = 32'h4000_0000 + $urandom % 32'h2_0000;
      bus_write(ADDR_CPU_MON_FIRST, base);
      bus_write(ADDR_CPU_MON_LAST, base + $urandom % 32'h400);
      bus_write(ADDR_CPU_MON_CTRL, $urandom);
      for (int i = 3; i < 250; i++) begin
        cpu = random_access(base, run % 2 == 1);
        if ($urandom % 8 == 0) bus_write(ADDR_CPU_MON_FIRST + 8'($urandom % 2), $urandom);
        else bus_idle();
      end
      cpu = '0;
    end

    // LED source selection and GPIO
    apply_reset();
    for (int i = 0; i < 500; i++) begin
      cpu_trap = ($urandom % 4) == 0;
      r = $urandom % 4;
      if (r == 0) bus_write(ADDR_LED, $urandom);
      else if (r == 1) bus_write(ADDR_GPIO, $urandom);
      else bus_read(r == 2 ? ADDR_GPIO : ADDR_LED);
    end

    cs = 1'b0;
    cpu_trap = 1'b0;
    tick();
    error_count += uut.props_i.fail_count;
    $display("Checks: %0d, errors: %0d (bound assertion failures: %0d)",
             check_count, error_count, uut.props_i.fail_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* tb/tk1_core_properties.sv */
`timescale 1ns/1ps

module tk1_core_properties (
  input logic        clk,
  input logic        reset_n,
  input logic        cs,
  input logic [31:0] read_data,
  input logic        ready,
  input logic        fw_app_mode,
  input logic        force_trap
);

  // Number of failed properties
  int fail_count = 0;

  // --------------------------------------------------------------------------
  // Register bus
  // --------------------------------------------------------------------------
  ready_follows_cs: assert property (@(posedge clk) ready == cs)
    else begin
      fail_count++;
      $error("ready differs from cs");
    end

  idle_read_zero: assert property (@(posedge clk) !cs |-> read_data == '0)
    else begin
      fail_count++;
      $error("read_data is not zero while cs is low");
    end

  // --------------------------------------------------------------------------
  // Sticky outputs, cleared only by reset
  // --------------------------------------------------------------------------
  app_mode_sticky: assert property (@(posedge clk) disable iff (!reset_n)
      $past(reset_n) |-> !$fell(fw_app_mode))
    else begin
      fail_count++;
      $error("fw_app_mode fell outside reset");
    end

  trap_sticky: assert property (@(posedge clk) disable iff (!reset_n)
      $past(reset_n) |-> !$fell(force_trap))
    else begin
      fail_count++;
      $error("force_trap fell outside reset");
    end

endmodule

bind tk1_core tk1_core_properties props_i (.*);

/* source/tk1_core.sv */
`timescale 1ns/1ps

module tk1_core (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cs,
  input  tk1_types_pkg::bus_req_t             req,
  input  tk1_types_pkg::cpu_access_t          cpu,
  input  logic                                cpu_trap,
  input  logic                                gpio1,
  input  logic                                gpio2,
  output logic [31:0]                         read_data,
  output logic                                ready,
  output logic                                fw_app_mode,
  output logic                                force_trap,
  output logic [tk1_reg_pkg::ASLR_WIDTH-1:0]  ram_aslr,
  output logic [31:0]                         ram_scramble,
  output logic                                led_r,
  output logic                                led_g,
  output logic                                led_b,
  output logic                                gpio3,
  output logic                                gpio4
);
  import tk1_types_pkg::*;

  mon_cfg_t    mon_cfg;
  logic [2:0]  led_value;
  logic        udi_addr;
  logic [31:0] udi_data;

  // Register file and bus decoder
  tk1_api api_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .req          (req),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .udi_data     (udi_data),
    .udi_addr     (udi_addr),
    .read_data    (read_data),
    .ready        (ready),
    .fw_app_mode  (fw_app_mode),
    .ram_aslr     (ram_aslr),
    .ram_scramble (ram_scramble),
    .gpio3        (gpio3),
    .gpio4        (gpio4),
    .led_value    (led_value),
    .mon_cfg      (mon_cfg)
  );

  security_monitor monitor_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .cpu        (cpu),
    .mon_cfg    (mon_cfg),
    .force_trap (force_trap)
  );

  status_led led_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .cpu_trap  (cpu_trap),
    .led_value (led_value),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b)
  );

  udi_rom rom_i (
    .addr (udi_addr),
    .data (udi_data)
  );

endmodule

/* source/tk1_api.sv */
`timescale 1ns/1ps

module tk1_api (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cs,
  input  tk1_types_pkg::bus_req_t             req,
  input  logic                                gpio1,
  input  logic                                gpio2,
  input  logic [31:0]                         udi_data,
  output logic                                udi_addr,
  output logic [31:0]                         read_data,
  output logic                                ready,
  output logic                                fw_app_mode,
  output logic [tk1_reg_pkg::ASLR_WIDTH-1:0]  ram_aslr,
  output logic [31:0]                         ram_scramble,
  output logic                                gpio3,
  output logic                                gpio4,
  output logic [2:0]                          led_value,
  output tk1_types_pkg::mon_cfg_t             mon_cfg
);
  import tk1_reg_pkg::*;

  // ---------------------------------------------------------------------------
  // Registers
  // ---------------------------------------------------------------------------
  logic                  switch_app_reg;
  logic [2:0]            led_reg;
  logic [1:0]            gpio1_sync;
  logic [1:0]            gpio2_sync;
  logic                  gpio3_reg;
  logic                  gpio4_reg;
  logic [31:0]           app_start_reg;
  logic [31:0]           app_size_reg;
  logic [31:0]           blake2s_addr_reg;
  logic [31:0]           cdi_mem [0:7];
  logic                  cdi_access_reg;
  logic [ASLR_WIDTH-1:0] ram_aslr_reg;
  logic [31:0]           ram_scramble_reg;
  logic                  mon_en_reg;
  logic [31:0]           mon_first_reg;
  logic [31:0]           mon_last_reg;

  logic write_en;
  logic read_en;
  logic in_cdi;
  logic in_udi;

  assign write_en = cs && req.we;
  assign read_en  = cs && !req.we;
  assign in_cdi   = (req.address >= ADDR_CDI_FIRST) && (req.address <= ADDR_CDI_LAST);
  assign in_udi   = (req.address >= ADDR_UDI_FIRST) && (req.address <= ADDR_UDI_LAST);

  // ---------------------------------------------------------------------------
  // Write path with firmware-mode and monitor locks
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      switch_app_reg   <= 1'b0;
      led_reg          <= LED_RESET;
      gpio3_reg        <= 1'b0;
      gpio4_reg        <= 1'b0;
      app_start_reg    <= '0;
      app_size_reg     <= '0;
      blake2s_addr_reg <= '0;
      cdi_access_reg   <= 1'b1;
      ram_aslr_reg     <= '0;
      ram_scramble_reg <= '0;
      mon_en_reg       <= 1'b0;
      mon_first_reg    <= '0;
      mon_last_reg     <= '0;
      for (int i = 0; i < 8; i++) begin
        cdi_mem[i] <= '0;
      end
    end else if (write_en) begin
      case (req.address)
        // One-way switch, data ignored
        ADDR_SWITCH_APP: switch_app_reg <= 1'b1;
        ADDR_LED:        led_reg <= req.write_data[2:0];
        ADDR_GPIO: begin
          gpio3_reg <= req.write_data[GPIO3_BIT];
          gpio4_reg <= req.write_data[GPIO4_BIT];
        end
        ADDR_APP_START: begin
          if (!switch_app_reg) app_start_reg <= req.write_data;
        end
        ADDR_APP_SIZE: begin
          if (!switch_app_reg) app_size_reg <= req.write_data;
        end
        ADDR_BLAKE2S: begin
          if (!switch_app_reg) blake2s_addr_reg <= req.write_data;
        end
        ADDR_RAM_ASLR: begin
          if (!switch_app_reg) ram_aslr_reg <= req.write_data[ASLR_WIDTH-1:0];
        end
        ADDR_RAM_SCRAMBLE: begin
          if (!switch_app_reg) ram_scramble_reg <= req.write_data;
        end
        ADDR_CPU_MON_CTRL: mon_en_reg <= 1'b1;
        // Window is frozen once the monitor is armed
        ADDR_CPU_MON_FIRST: begin
          if (!mon_en_reg) mon_first_reg <= req.write_data;
        end
        ADDR_CPU_MON_LAST: begin
          if (!mon_en_reg) mon_last_reg <= req.write_data;
        end
        default: ;
      endcase

      // CDI is written by firmware only, every other write hides it
      if (in_cdi && !switch_app_reg) begin
        cdi_mem[req.address[2:0]] <= req.write_data;
      end else begin
        cdi_access_reg <= 1'b0;
      end
    end
  end

  // Two-flop synchronizers for the GPIO inputs
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gpio1_sync <= '0;
      gpio2_sync <= '0;
    end else begin
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};
    end
  end

  // ---------------------------------------------------------------------------
  // Same-cycle read mux
  // ---------------------------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (read_en) begin
      case (req.address)
        ADDR_NAME0:      read_data = CORE_NAME0;
        ADDR_NAME1:      read_data = CORE_NAME1;
        ADDR_VERSION:    read_data = CORE_VERSION;
        ADDR_SWITCH_APP: read_data = {32{switch_app_reg}};
        ADDR_LED:        read_data = {29'h0, led_reg};
        ADDR_GPIO: begin
          read_data = {28'h0, gpio4_reg, gpio3_reg, gpio2_sync[1], gpio1_sync[1]};
        end
        ADDR_APP_START:  read_data = app_start_reg;
        ADDR_APP_SIZE:   read_data = app_size_reg;
        ADDR_BLAKE2S:    read_data = blake2s_addr_reg;
        default: begin
          if (in_cdi && cdi_access_reg) begin
            read_data = cdi_mem[req.address[2:0]];
          end
          // UDI only visible to firmware
          if (in_udi && !switch_app_reg) begin
            read_data = udi_data;
          end
        end
      endcase
    end
  end

  assign ready        = cs;
  assign udi_addr     = req.address[0];
  assign fw_app_mode  = switch_app_reg;
  assign ram_aslr     = ram_aslr_reg;
  assign ram_scramble = ram_scramble_reg;
  assign gpio3        = gpio3_reg;
  assign gpio4        = gpio4_reg;
  assign led_value    = led_reg;
  assign mon_cfg      = '{en: mon_en_reg, first: mon_first_reg, last: mon_last_reg};

endmodule

/* security_monitor/security_monitor.sv */
`timescale 1ns/1ps

module security_monitor (
  input  logic                        clk,
  input  logic                        reset_n,
  input  tk1_types_pkg::cpu_access_t  cpu,
  input  tk1_types_pkg::mon_cfg_t     mon_cfg,
  output logic                        force_trap
);
  import tk1_reg_pkg::*;

  logic out_of_ram;
  logic fw_ram_exec;
  logic window_exec;
  logic violation;
  logic force_trap_reg;

  // ---------------------------------------------------------------------------
  // Access rules
  // ---------------------------------------------------------------------------
  // RAM region decodes at 01 in the top bits, only 128 KiB is populated
  assign out_of_ram = (cpu.addr[31:30] == 2'b01) && (|cpu.addr[29:17]);

  // Firmware RAM holds data only
  assign fw_ram_exec = cpu.instr &&
                       (cpu.addr >= FW_RAM_FIRST) &&
                       (cpu.addr <= FW_RAM_LAST);

  // Application-defined no-execute window, once armed
  assign window_exec = cpu.instr && mon_cfg.en &&
                       (cpu.addr >= mon_cfg.first) &&
                       (cpu.addr <= mon_cfg.last);

  assign violation = cpu.valid && (out_of_ram || fw_ram_exec || window_exec);

  // ---------------------------------------------------------------------------
  // Sticky trap request, cleared only by reset
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap_reg <= 1'b0;
    end else if (violation) begin
      force_trap_reg <= 1'b1;
    end
  end

  assign force_trap = force_trap_reg;

endmodule

/* source/status_led.sv */
`timescale 1ns/1ps

module status_led (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       cpu_trap,
  input  logic [2:0] led_value,
  output logic       led_r,
  output logic       led_g,
  output logic       led_b
);
  import tk1_reg_pkg::*;

  logic [TRAP_BLINK_BITS-1:0] blink_ctr;
  logic [2:0]                 blink_state;
  logic [2:0]                 led_mux;

  // ---------------------------------------------------------------------------
  // Trap blink generator
  // ---------------------------------------------------------------------------
  // Red toggles each time the counter wraps, first on the edge after reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr   <= '0;
      blink_state <= '0;
    end else begin
      blink_ctr <= blink_ctr + 1'b1;
      if (blink_ctr == '0) begin
        blink_state[LED_R_BIT] <= ~blink_state[LED_R_BIT];
      end
    end
  end

  // Trap pattern overrides the software value
  assign led_mux = cpu_trap ? blink_state : led_value;

  assign led_r = led_mux[LED_R_BIT];
  assign led_g = led_mux[LED_G_BIT];
  assign led_b = led_mux[LED_B_BIT];

endmodule

/* source/udi_rom.sv */
`timescale 1ns/1ps

module udi_rom (
  input  logic        addr,
  output logic [31:0] data
);
  import tk1_reg_pkg::*;

  // Stand-in for the device-programmed identity ROM
  always_comb begin
    case (addr)
      1'b0:    data = UDI_WORD0;
      default: data = UDI_WORD1;
    endcase
  end

endmodule

/* common/tk1_types_pkg.sv */
package tk1_types_pkg;

  // ---------------------------------------------------------------------------
  // Register bus request, qualified by cs
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic        we;
    logic [7:0]  address;
    logic [31:0] write_data;
  } bus_req_t;

  // ---------------------------------------------------------------------------
  // CPU memory access as seen by the monitor
  // ---------------------------------------------------------------------------
  typedef struct packed {
    logic        valid;
    // High for an instruction fetch
    logic        instr;
    logic [31:0] addr;
  } cpu_access_t;

  // Execution monitor window, inclusive bounds
  typedef struct packed {
    logic        en;
    logic [31:0] first;
    logic [31:0] last;
  } mon_cfg_t;

endpackage

/* common/tk1_reg_pkg.sv */
package tk1_reg_pkg;

  // ---------------------------------------------------------------------------
  // Register address map
  // ---------------------------------------------------------------------------
  localparam logic [7:0] ADDR_NAME0         = 8'h00;
  localparam logic [7:0] ADDR_NAME1         = 8'h01;
  localparam logic [7:0] ADDR_VERSION       = 8'h02;
  localparam logic [7:0] ADDR_SWITCH_APP    = 8'h08;
  localparam logic [7:0] ADDR_LED           = 8'h09;
  localparam logic [7:0] ADDR_GPIO          = 8'h0a;
  localparam logic [7:0] ADDR_APP_START     = 8'h0c;
  localparam logic [7:0] ADDR_APP_SIZE      = 8'h0d;
  localparam logic [7:0] ADDR_BLAKE2S       = 8'h10;
  localparam logic [7:0] ADDR_CDI_FIRST     = 8'h20;
  localparam logic [7:0] ADDR_CDI_LAST      = 8'h27;
  localparam logic [7:0] ADDR_UDI_FIRST     = 8'h30;
  localparam logic [7:0] ADDR_UDI_LAST      = 8'h31;
  localparam logic [7:0] ADDR_RAM_ASLR      = 8'h40;
  localparam logic [7:0] ADDR_RAM_SCRAMBLE  = 8'h41;
  localparam logic [7:0] ADDR_CPU_MON_CTRL  = 8'h60;
  localparam logic [7:0] ADDR_CPU_MON_FIRST = 8'h61;
  localparam logic [7:0] ADDR_CPU_MON_LAST  = 8'h62;

  // Identity words, ASCII "tk1 " and "mkdf"
  localparam logic [31:0] CORE_NAME0   = 32'h746b3120;
  localparam logic [31:0] CORE_NAME1   = 32'h6d6b6466;
  localparam logic [31:0] CORE_VERSION = 32'h00000005;

  // Firmware RAM, never executable
  localparam logic [31:0] FW_RAM_FIRST = 32'hd0000000;
  localparam logic [31:0] FW_RAM_LAST  = 32'hd00007ff;

  // Device identity as programmed into the ROM
  localparam logic [31:0] UDI_WORD0 = 32'h00010203;
  localparam logic [31:0] UDI_WORD1 = 32'h04050607;

  // Bit positions and widths
  localparam int LED_R_BIT       = 2;
  localparam int LED_G_BIT       = 1;
  localparam int LED_B_BIT       = 0;
  localparam int GPIO3_BIT       = 2;
  localparam int GPIO4_BIT       = 3;
  localparam logic [2:0] LED_RESET = 3'b110;
  localparam int ASLR_WIDTH      = 15;
  localparam int TRAP_BLINK_BITS = 24;

endpackage
